// ==== Makefile ====
# Verilator flow for the SPI to Avalon-MM bridge

VERILATOR  ?= verilator
FILELIST   := src.f
TOP        := spi_avmm_bridge_tb
LINT_FLAGS := --lint-only --timing --assert
SIM_FLAGS  := --binary --timing --assert -j 0
RUN_FLAGS  := +verilator+error+limit+1000
OBJ_DIR    := obj_dir
LOG        := sim.log
FAIL_MSG   := Something failed
PASS_MSG   := Everything OK

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	-./$(OBJ_DIR)/V$(TOP) $(RUN_FLAGS) 2>&1 | tee $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then echo "Simulation failed"; exit 1; fi
	@if ! grep -q "$(PASS_MSG)" $(LOG); then echo "Simulation did not finish"; exit 1; fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// ==== dv/spi_avmm_bridge_chk.sv ====
// Bound checker for the Avalon-MM host port
//   Read and write exclusive, command stable under waitrequest
//   Full byte enables and no new request while a command is pending

`timescale 1ns/1ps

module spi_avmm_bridge_chk (
   input logic                               i_avmm_clk,
   input logic                               i_rst_n,
   input avmm_pkg::avmm_req_t                i_req,
   input logic                               i_avmm_waitreq,
   input logic                               i_avmm_write,
   input logic                               i_avmm_read,
   input logic [avmm_pkg::AVMM_ADDR_W-1:0]   i_avmm_addr,
   input logic [avmm_pkg::AVMM_DATA_W-1:0]   i_avmm_wdata,
   input logic [avmm_pkg::AVMM_DATA_W/8-1:0] i_avmm_byte_en
);

   int   fail_cnt = 0;     // Assertion failures so far
   logic cmd_active;
   logic req_new;

   assign cmd_active = i_avmm_write | i_avmm_read;
   assign req_new    = i_req.write | i_req.read;

   a_rd_wr_excl: assert property (@(posedge i_avmm_clk) disable iff (!i_rst_n)
      !(i_avmm_write && i_avmm_read))
      else begin
         fail_cnt++;
         $error("Avalon read and write high together");
      end

   // Held command must not move while the slave stalls
   a_hold_stable: assert property (@(posedge i_avmm_clk) disable iff (!i_rst_n)
      (cmd_active && i_avmm_waitreq) |=> ($stable(i_avmm_addr) && $stable(i_avmm_wdata)
                                          && $stable(i_avmm_write) && $stable(i_avmm_read)))
      else begin
         fail_cnt++;
         $error("Avalon command changed under waitrequest");
      end

   a_byte_en: assert property (@(posedge i_avmm_clk) disable iff (!i_rst_n)
      cmd_active |-> (i_avmm_byte_en == '1))
      else begin
         fail_cnt++;
         $error("Byte enables not all ones during a command");
      end

   a_one_pending: assert property (@(posedge i_avmm_clk) disable iff (!i_rst_n)
      req_new |-> !cmd_active)
      else begin
         fail_cnt++;
         $error("New request while a command is pending");
      end

endmodule

bind avmm_master_port spi_avmm_bridge_chk u_avmm_chk (
   .i_avmm_clk     (i_avmm_clk),
   .i_rst_n        (i_rst_n),
   .i_req          (i_req),
   .i_avmm_waitreq (i_avmm_waitreq),
   .i_avmm_write   (o_avmm_write),
   .i_avmm_read    (o_avmm_read),
   .i_avmm_addr    (o_avmm_addr),
   .i_avmm_wdata   (o_avmm_wdata),
   .i_avmm_byte_en (o_avmm_byte_en)
);

// ==== dv/spi_avmm_bridge_tb.sv ====
// Testbench for the SPI to Avalon-MM bridge
//   Clock, reset and a mode 0 SPI controller
//   Avalon memory model with random waitrequest and a write log
//   Directed tests with one result line each and a summary line

`timescale 1ns/1ps

module spi_avmm_bridge_tb;
   import avmm_pkg::*;

   localparam int HALF      = 10;                  // sclk half period in clocks
   localparam int MEM_WORDS = 1 << AVMM_ADDR_W;
   localparam logic [16:0] A_SINGLE = 17'h1_2345;
   localparam logic [16:0] A_BURST  = 17'h0_0ffe;
   localparam logic [16:0] A_STALL  = 17'h0_8000;
   localparam logic [16:0] A_ABORT  = 17'h0_4321;
   localparam logic [31:0] W_SINGLE = 32'hdead_beef;

   logic                   clk;
   logic                   rst_n = 1'b0;
   logic                   sclk = 1'b0;
   logic                   ss_n = 1'b1;
   logic                   mosi = 1'b0;
   logic                   miso;
   logic                   avmm_write;
   logic                   avmm_read;
   logic [AVMM_ADDR_W-1:0] avmm_addr;
   logic [AVMM_DATA_W-1:0] avmm_wdata;
   logic [3:0]             avmm_byte_en;
   logic                   waitreq = 1'b0;
   logic                   rdatavld = 1'b0;
   logic [AVMM_DATA_W-1:0] rdata = '0;

   logic [AVMM_DATA_W-1:0] mem [MEM_WORDS];
   logic [AVMM_ADDR_W-1:0] log_addr [$];            // Accepted writes, in order
   logic [AVMM_DATA_W-1:0] log_data [$];
   logic [AVMM_DATA_W-1:0] exp_data [$];
   logic [7:0]             tx_bytes [$];
   logic [7:0]             rx_bytes [$];
   logic [1:0]             rd_pipe = 2'b00;
   logic [31:0]            rd_word0;
   logic [31:0]            rd_word1;
   logic [31:0]            rnd;
   logic                   vld_next;
   logic [31:0]            data_next;
   logic [31:0]            rx_word;
   logic                   heavy_stall = 1'b0;
   int                     stall_run = 0;
   integer                 seed = 56;
   int                     test_errs = 0;
   int                     errors = 0;
   int                     n_pass = 0;
   int                     n_fail = 0;
   int                     chk_fails;

   initial begin
      clk = 1'b0;
      forever #5 clk = ~clk;
   end

   spi_avmm_bridge #(
      .SYNC_STAGES (2)
   ) u_spi_avmm_bridge (
      .i_avmm_clk      (clk),
      .i_rst_n         (rst_n),
      .i_sclk          (sclk),
      .i_ss_n          (ss_n),
      .i_mosi          (mosi),
      .o_miso          (miso),
      .o_avmm_write    (avmm_write),
      .o_avmm_read     (avmm_read),
      .o_avmm_addr     (avmm_addr),
      .o_avmm_wdata    (avmm_wdata),
      .o_avmm_byte_en  (avmm_byte_en),
      .i_avmm_waitreq  (waitreq),
      .i_avmm_rdatavld (rdatavld),
      .i_avmm_rdata    (rdata)
   );

   ////////////////////////////////////////////////////////////////////////////
   // Avalon memory model
   ////////////////////////////////////////////////////////////////////////////

   function automatic logic [31:0] fill_word(input logic [16:0] a);
      return {~a[14:0], a};
   endfunction

   always @(posedge clk) begin
      if (rst_n && avmm_write && !waitreq) begin
         mem[avmm_addr] = avmm_wdata;
         log_addr.push_back(avmm_addr);
         log_data.push_back(avmm_wdata);
      end
      vld_next  = rd_pipe[1];                         // Two cycles after acceptance
      data_next = rd_word1;
      rd_word1  = rd_word0;
      rd_word0  = mem[avmm_addr];
      rd_pipe   = {rd_pipe[0], rst_n && avmm_read && !waitreq};
      rnd       = $random(seed);
      #1;
      rdatavld = vld_next;
      rdata    = data_next;
      waitreq  = heavy_stall ? (rnd[2:0] != 3'd0) : (rnd[1:0] == 2'd0);
      if (stall_run >= 20) waitreq = 1'b0;            // Stall limit
      stall_run = waitreq ? stall_run + 1 : 0;
   end

   ////////////////////////////////////////////////////////////////////////////
   // SPI controller, mode 0
   ////////////////////////////////////////////////////////////////////////////

   task automatic tick(input int n);
      repeat (n) @(posedge clk);
      #1;
   endtask

   task automatic spi_byte(input logic [7:0] tx, output logic [7:0] rx);
      logic [7:0] sh;
      sh = tx;
      rx = '0;
      repeat (8) begin
         mosi = sh[7];
         sh   = {sh[6:0], 1'b0};
         tick(HALF);
         sclk = 1'b1;
         rx   = {rx[6:0], miso};                       // MISO settled since the fall
         tick(HALF);
         sclk = 1'b0;
      end
   endtask

   task automatic spi_frame();
      logic [7:0] rx;
      rx_bytes.delete();
      ss_n = 1'b0;
      tick(HALF);
      foreach (tx_bytes[i]) begin
         spi_byte(tx_bytes[i], rx);
         rx_bytes.push_back(rx);
      end
      tick(HALF);
      ss_n = 1'b1;
      tick(4 * HALF);
   endtask

   task automatic put_header(input logic wr, input logic [16:0] addr);
      tx_bytes.delete();
      tx_bytes.push_back({wr, 6'd0, addr[16]});
      tx_bytes.push_back(addr[15:8]);
      tx_bytes.push_back(addr[7:0]);
   endtask

   task automatic put_word(input logic [31:0] w);
      tx_bytes.push_back(w[31:24]);
      tx_bytes.push_back(w[23:16]);
      tx_bytes.push_back(w[15:8]);
      tx_bytes.push_back(w[7:0]);
      exp_data.push_back(w);
   endtask

   ////////////////////////////////////////////////////////////////////////////
   // Checks and bookkeeping
   ////////////////////////////////////////////////////////////////////////////

   task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
      assert (got === exp)
      else begin
         $display("[ERROR] %0t ns %s: got %h, expected %h", $time, name, got, exp);
         test_errs++;
      end
   endtask

   task automatic start_test();
      log_addr.delete();
      log_data.delete();
      exp_data.delete();
   endtask

   task automatic end_test(input string name);
      if (test_errs == 0) begin
         n_pass++;
         $display("%0t ns test %s: passed", $time, name);
      end else begin
         n_fail++;
         $display("%0t ns test %s: failed with %0d errors", $time, name, test_errs);
      end
      errors += test_errs;
      test_errs = 0;
   endtask

   task automatic wait_writes(input int n);
      int cnt;
      cnt = 0;
      while (log_addr.size() < n && cnt < 2000) begin
         tick(1);
         cnt++;
      end
      assert (log_addr.size() >= n)
      else begin
         $display("Timeout while waiting for %0d Avalon writes", n);
         test_errs++;
      end
      tick(40);                                       // Room for a stray extra write
   endtask

   task automatic check_writes(input logic [16:0] base);
      check("write count", 32'(log_addr.size()), 32'(exp_data.size()));
      for (int k = 0; k < exp_data.size() && k < log_addr.size(); k++) begin
         check("o_avmm_addr", 32'(log_addr[k]), 32'(base + 17'(k)));
         check("o_avmm_wdata", log_data[k], exp_data[k]);
      end
   endtask

   ////////////////////////////////////////////////////////////////////////////
   // Tests
   ////////////////////////////////////////////////////////////////////////////

   initial begin
      $timeformat(-9, 0, "", 0);
      for (int a = 0; a < MEM_WORDS; a++) mem[17'(a)] = fill_word(17'(a));

      repeat (8) begin
         tick(1);
         check("o_avmm_write", 32'(avmm_write), 32'd0);
         check("o_avmm_read", 32'(avmm_read), 32'd0);
         check("o_miso", 32'(miso), 32'd0);
      end
      rst_n = 1'b1;
      repeat (4) begin
         tick(1);
         check("o_avmm_write", 32'(avmm_write), 32'd0);
         check("o_avmm_read", 32'(avmm_read), 32'd0);
         check("o_miso", 32'(miso), 32'd0);
      end
      end_test("reset");

      start_test();
      put_header(1'b1, A_SINGLE);
      put_word(W_SINGLE);
      spi_frame();
      wait_writes(exp_data.size());
      check_writes(A_SINGLE);
      end_test("single write");

      start_test();
      put_header(1'b1, A_BURST);
      put_word(32'h0102_0304);
      put_word(32'ha5a5_5a5a);
      put_word(32'h8000_0001);
      spi_frame();
      wait_writes(exp_data.size());
      check_writes(A_BURST);
      end_test("burst write");

      // Turnaround byte, then four bytes of read data
      start_test();
      put_header(1'b0, A_SINGLE);
      repeat (5) tx_bytes.push_back(8'h00);
      spi_frame();
      rx_word = {rx_bytes[4], rx_bytes[5], rx_bytes[6], rx_bytes[7]};
      check("o_miso", rx_word, W_SINGLE);
      check("write count", 32'(log_addr.size()), 32'd0);
      end_test("read");

      start_test();
      heavy_stall = 1'b1;
      put_header(1'b1, A_STALL);
      repeat (4) put_word($random(seed));
      spi_frame();
      wait_writes(exp_data.size());
      check_writes(A_STALL);
      heavy_stall = 1'b0;
      end_test("back-pressure");

      // ss_n rises after half a word
      start_test();
      put_header(1'b1, A_ABORT);
      tx_bytes.push_back(8'h11);
      tx_bytes.push_back(8'h22);
      spi_frame();
      tick(100);
      check("write count", 32'(log_addr.size()), 32'd0);
      check("mem", mem[A_ABORT], fill_word(A_ABORT));
      end_test("abort");

      chk_fails = u_spi_avmm_bridge.u_avmm_master_port.u_avmm_chk.fail_cnt;
      $display("Tests passed %0d, failed %0d, check errors %0d, assertion failures %0d",
               n_pass, n_fail, errors, chk_fails);
      if (errors == 0 && n_fail == 0 && chk_fails == 0) begin
         $display("Everything OK");
      end else begin
         $display("Something failed");
      end
      $finish;
   end

   // Run limit
   initial begin
      repeat (100000) @(posedge clk);
      $display("Timeout, the tests did not finish in time");
      $display("Something failed");
      $finish;
   end

endmodule

// ==== source/avmm_master_port.sv ====
// Avalon-MM host port
//   Turns request strobes into a held write or read command
//   Keeps address and data stable while waitrequest is high
//   Captures read data on rdatavalid into the response

`timescale 1ns/1ps

module avmm_master_port (
   input  logic                                 i_avmm_clk,
   input  logic                                 i_rst_n,
   input  avmm_pkg::avmm_req_t                  i_req,
   input  logic                                 i_avmm_waitreq,
   input  logic                                 i_avmm_rdatavld,
   input  logic [avmm_pkg::AVMM_DATA_W-1:0]     i_avmm_rdata,
   output logic                                 o_avmm_write,
   output logic                                 o_avmm_read,
   output logic [avmm_pkg::AVMM_ADDR_W-1:0]     o_avmm_addr,
   output logic [avmm_pkg::AVMM_DATA_W-1:0]     o_avmm_wdata,
   output logic [avmm_pkg::AVMM_DATA_W/8-1:0]   o_avmm_byte_en,
   output avmm_pkg::avmm_rsp_t                  o_rsp
);
   import avmm_pkg::*;

   localparam int BE_W = AVMM_DATA_W / 8;

   logic                   req_new;
   logic                   cmd_wr_q;
   logic                   cmd_rd_q;
   logic                   cmd_active;
   logic [AVMM_ADDR_W-1:0] addr_q;
   logic [AVMM_DATA_W-1:0] wdata_q;
   logic                   rsp_vld_q;
   logic [AVMM_DATA_W-1:0] rdata_q;

   assign req_new    = i_req.write | i_req.read;
   assign cmd_active = cmd_wr_q | cmd_rd_q;

   // Command held until a cycle with waitrequest low
   always_ff @(posedge i_avmm_clk) begin
      if (!i_rst_n) begin
         cmd_wr_q  <= 1'b0;
         cmd_rd_q  <= 1'b0;
         rsp_vld_q <= 1'b0;
      end else begin
         if (req_new) begin
            cmd_wr_q <= i_req.write;
            cmd_rd_q <= i_req.read;
         end else if (!i_avmm_waitreq) begin
            cmd_wr_q <= 1'b0;                // Accepted
            cmd_rd_q <= 1'b0;
         end
         rsp_vld_q <= i_avmm_rdatavld;
      end
   end

   always_ff @(posedge i_avmm_clk) begin
      if (req_new) begin
         addr_q  <= i_req.addr;
         wdata_q <= i_req.wdata;
      end
      if (i_avmm_rdatavld) begin
         rdata_q <= i_avmm_rdata;
      end
   end

   assign o_avmm_write   = cmd_wr_q;
   assign o_avmm_read    = cmd_rd_q;
   assign o_avmm_addr    = addr_q;
   assign o_avmm_wdata   = wdata_q;
   assign o_avmm_byte_en = {BE_W{cmd_active}};  // Word accesses only

   assign o_rsp = '{vld: rsp_vld_q, rdata: rdata_q};

endmodule

// ==== source/avmm_pkg.sv ====
// Avalon-MM side definitions for the SPI to Avalon-MM bridge
//   Address and data widths of the host port
//   Request struct from the frame decoder
//   Response struct with captured read data

package avmm_pkg;

   localparam int AVMM_ADDR_W = 17;  // Word address
   localparam int AVMM_DATA_W = 32;

   // One-cycle strobe, write or read set, never both
   typedef struct packed {
      logic                   write;
      logic                   read;
      logic [AVMM_ADDR_W-1:0] addr;
      logic [AVMM_DATA_W-1:0] wdata;
   } avmm_req_t;

   // vld pulses one cycle after rdatavalid
   typedef struct packed {
      logic                   vld;
      logic [AVMM_DATA_W-1:0] rdata;
   } avmm_rsp_t;

endpackage

// ==== source/spi_avmm_bridge.sv ====
// SPI target to Avalon-MM host bridge, top level
//   Receive, frame decode, Avalon port and transmit stages
//   Single clock, sclk is oversampled on the Avalon clock

`timescale 1ns/1ps

module spi_avmm_bridge #(
   parameter int SYNC_STAGES = 2
) (
   input  logic                               i_avmm_clk,
   input  logic                               i_rst_n,
   // SPI target, mode 0
   input  logic                               i_sclk,
   input  logic                               i_ss_n,
   input  logic                               i_mosi,
   output logic                               o_miso,
   // Avalon-MM host
   output logic                               o_avmm_write,
   output logic                               o_avmm_read,
   output logic [avmm_pkg::AVMM_ADDR_W-1:0]   o_avmm_addr,
   output logic [avmm_pkg::AVMM_DATA_W-1:0]   o_avmm_wdata,
   output logic [avmm_pkg::AVMM_DATA_W/8-1:0] o_avmm_byte_en,
   input  logic                               i_avmm_waitreq,
   input  logic                               i_avmm_rdatavld,
   input  logic [avmm_pkg::AVMM_DATA_W-1:0]   i_avmm_rdata
);
   import spi_pkg::*;
   import avmm_pkg::*;

   spi_evt_t  spi_evt;
   avmm_req_t avmm_req;
   avmm_rsp_t avmm_rsp;
   logic      tx_arm;

   spi_rx_shift #(
      .SYNC_STAGES (SYNC_STAGES)
   ) u_spi_rx_shift (
      .i_avmm_clk (i_avmm_clk),
      .i_rst_n    (i_rst_n),
      .i_sclk     (i_sclk),
      .i_ss_n     (i_ss_n),
      .i_mosi     (i_mosi),
      .o_evt      (spi_evt)
   );

   spi_frame_decode u_spi_frame_decode (
      .i_avmm_clk (i_avmm_clk),
      .i_rst_n    (i_rst_n),
      .i_evt      (spi_evt),
      .o_req      (avmm_req),
      .o_tx_arm   (tx_arm)
   );

   avmm_master_port u_avmm_master_port (
      .i_avmm_clk      (i_avmm_clk),
      .i_rst_n         (i_rst_n),
      .i_req           (avmm_req),
      .i_avmm_waitreq  (i_avmm_waitreq),
      .i_avmm_rdatavld (i_avmm_rdatavld),
      .i_avmm_rdata    (i_avmm_rdata),
      .o_avmm_write    (o_avmm_write),
      .o_avmm_read     (o_avmm_read),
      .o_avmm_addr     (o_avmm_addr),
      .o_avmm_wdata    (o_avmm_wdata),
      .o_avmm_byte_en  (o_avmm_byte_en),
      .o_rsp           (avmm_rsp)
   );

   spi_tx_shift u_spi_tx_shift (
      .i_avmm_clk (i_avmm_clk),
      .i_rst_n    (i_rst_n),
      .i_evt      (spi_evt),
      .i_rsp      (avmm_rsp),
      .i_tx_arm   (tx_arm),
      .o_miso     (o_miso)
   );

endmodule

// ==== source/spi_frame_decode.sv ====
// SPI frame decoder
//   Parses the three byte header into command bit and word address
//   Collects four bytes per write word and issues one write per word
//   Issues the read after the header and arms transmit after turnaround

`timescale 1ns/1ps

module spi_frame_decode (
   input  logic                i_avmm_clk,
   input  logic                i_rst_n,
   input  spi_pkg::spi_evt_t   i_evt,
   output avmm_pkg::avmm_req_t o_req,
   output logic                o_tx_arm
);
   import spi_pkg::*;
   import avmm_pkg::*;

   localparam logic [1:0] HDR_LAST  = 2'(SPI_HDR_BYTES - 1);
   localparam logic [1:0] WORD_LAST = 2'(SPI_WORD_BYTES - 1);

   logic                   frame_clr;
   logic                   in_hdr;     // Header bytes still expected
   logic [1:0]             hdr_cnt;
   logic [1:0]             wbyte_cnt;  // Bytes of the current write word
   logic                   cmd_wr;
   logic                   ta_wait;    // Read frame, turnaround byte pending
   logic                   req_wr;
   logic                   req_rd;
   logic                   tx_arm;
   logic [AVMM_ADDR_W-1:0] addr_q;
   logic [AVMM_DATA_W-1:0] wdata_q;

   assign frame_clr = i_evt.frame_start | i_evt.frame_end;

   ////////////////////////////////////////////////////////////////////////////
   // Frame sequencing
   ////////////////////////////////////////////////////////////////////////////

   always_ff @(posedge i_avmm_clk) begin
      if (!i_rst_n) begin
         in_hdr    <= 1'b1;
         hdr_cnt   <= '0;
         wbyte_cnt <= '0;
         cmd_wr    <= 1'b0;
         ta_wait   <= 1'b0;
         req_wr    <= 1'b0;
         req_rd    <= 1'b0;
         tx_arm    <= 1'b0;
      end else begin
         req_wr <= 1'b0;
         req_rd <= 1'b0;
         tx_arm <= 1'b0;

         if (frame_clr) begin
            // A partial word is simply forgotten here
            in_hdr    <= 1'b1;
            hdr_cnt   <= '0;
            wbyte_cnt <= '0;
            ta_wait   <= 1'b0;
         end else if (i_evt.byte_vld) begin
            if (in_hdr) begin
               hdr_cnt <= hdr_cnt + 2'd1;
               if (hdr_cnt == 2'd0) begin
                  cmd_wr <= i_evt.data[SPI_CMD_WRITE_BIT];
               end
               if (hdr_cnt == HDR_LAST) begin
                  in_hdr  <= 1'b0;
                  req_rd  <= ~cmd_wr;
                  ta_wait <= ~cmd_wr;
               end
            end else if (cmd_wr) begin
               wbyte_cnt <= wbyte_cnt + 2'd1;
               req_wr    <= (wbyte_cnt == WORD_LAST);
            end else if (ta_wait) begin
               ta_wait <= 1'b0;
               tx_arm  <= 1'b1;
            end
         end
      end
   end

   ////////////////////////////////////////////////////////////////////////////
   // Address and write data
   ////////////////////////////////////////////////////////////////////////////

   always_ff @(posedge i_avmm_clk) begin
      if (req_wr) begin
         addr_q <= addr_q + AVMM_ADDR_W'(1);  // Next word of the burst
      end
      if (i_evt.byte_vld && in_hdr) begin
         case (hdr_cnt)
            2'd0:    addr_q[AVMM_ADDR_W-1] <= i_evt.data[0];
            2'd1:    addr_q[15:8] <= i_evt.data;
            default: addr_q[7:0] <= i_evt.data;
         endcase
      end
      if (i_evt.byte_vld && !in_hdr && cmd_wr) begin
         wdata_q <= {wdata_q[AVMM_DATA_W-9:0], i_evt.data};  // MSB first
      end
   end

   assign o_req = '{write: req_wr,
                    read:  req_rd,
                    addr:  addr_q,
                    wdata: wdata_q};

   assign o_tx_arm = tx_arm;

endmodule

// ==== source/spi_pkg.sv ====
// SPI side definitions for the SPI to Avalon-MM bridge
//   Frame layout constants for the three byte header and data words
//   Per-cycle serial event passed from the receive stage

package spi_pkg;

   ////////////////////////////////////////////////////////////////////////////
   // Frame layout
   ////////////////////////////////////////////////////////////////////////////

   localparam int SPI_HDR_BYTES     = 3;  // Command/addr[16], addr[15:8], addr[7:0]
   localparam int SPI_WORD_BYTES    = 4;  // One 32-bit word, MSB first
   localparam int SPI_CMD_WRITE_BIT = 7;  // Header byte 0, 1 = write

   ////////////////////////////////////////////////////////////////////////////
   // Serial event from the receive stage
   ////////////////////////////////////////////////////////////////////////////

   // All fields are registered and valid every cycle.
   // Pulses last one cycle of the oversampling clock.
   typedef struct packed {
      logic       sel;          // ss_n low after sync
      logic       frame_start;  // ss_n fell
      logic       frame_end;    // ss_n rose
      logic       sclk_fall;    // Falling sclk while selected
      logic       byte_vld;     // Eighth rising edge seen
      logic [7:0] data;         // Completed byte
   } spi_evt_t;

endpackage

// ==== source/spi_rx_shift.sv ====
// SPI receive stage
//   Synchronizes sclk, ss_n and mosi onto the Avalon clock
//   Detects sclk and ss_n edges by comparison with the previous sample
//   Shifts MOSI in on rising sclk, mode 0 only, and reports each byte

`timescale 1ns/1ps

module spi_rx_shift #(
   parameter int SYNC_STAGES = 2
) (
   input  logic              i_avmm_clk,
   input  logic              i_rst_n,
   input  logic              i_sclk,
   input  logic              i_ss_n,
   input  logic              i_mosi,
   output spi_pkg::spi_evt_t o_evt
);
   import spi_pkg::*;

   localparam int MSB = SYNC_STAGES - 1;

   logic [MSB:0] sclk_sync;
   logic [MSB:0] ss_n_sync;
   logic [MSB:0] mosi_sync;
   logic         sclk_d;      // Previous synchronized sclk
   logic         ss_n_d;
   logic         sel;
   logic         sclk_rise;
   logic         sclk_fall;
   logic         ss_fall;
   logic         ss_rise;
   logic [2:0]   bit_cnt;
   logic [6:0]   shift_q;     // First seven bits of the byte
   logic [7:0]   data_q;
   logic         sel_q;
   logic         start_q;
   logic         end_q;
   logic         fall_q;
   logic         byte_q;

   assign sel       = ~ss_n_sync[MSB];
   assign sclk_rise = sel &  sclk_sync[MSB] & ~sclk_d;
   assign sclk_fall = sel & ~sclk_sync[MSB] &  sclk_d;
   assign ss_fall   = ~ss_n_sync[MSB] &  ss_n_d;
   assign ss_rise   =  ss_n_sync[MSB] & ~ss_n_d;

   always_ff @(posedge i_avmm_clk) begin
      if (!i_rst_n) begin
         sclk_sync <= '0;
         ss_n_sync <= '1;            // Deselected
         mosi_sync <= '0;
         sclk_d    <= 1'b0;
         ss_n_d    <= 1'b1;
         bit_cnt   <= '0;
         sel_q     <= 1'b0;
         start_q   <= 1'b0;
         end_q     <= 1'b0;
         fall_q    <= 1'b0;
         byte_q    <= 1'b0;
      end else begin
         sclk_sync <= {sclk_sync[MSB-1:0], i_sclk};
         ss_n_sync <= {ss_n_sync[MSB-1:0], i_ss_n};
         mosi_sync <= {mosi_sync[MSB-1:0], i_mosi};
         sclk_d    <= sclk_sync[MSB];
         ss_n_d    <= ss_n_sync[MSB];

         // Byte alignment restarts with every frame
         if (ss_fall) begin
            bit_cnt <= '0;
         end else if (sclk_rise) begin
            bit_cnt <= bit_cnt + 3'd1;
         end

         sel_q   <= sel;
         start_q <= ss_fall;
         end_q   <= ss_rise;
         fall_q  <= sclk_fall;
         byte_q  <= sclk_rise && (bit_cnt == 3'd7);
      end
   end

   // Serial data path
   always_ff @(posedge i_avmm_clk) begin
      if (sclk_rise) begin
         shift_q <= {shift_q[5:0], mosi_sync[MSB]};
         if (bit_cnt == 3'd7) begin
            data_q <= {shift_q, mosi_sync[MSB]};
         end
      end
   end

   assign o_evt = '{sel:         sel_q,
                    frame_start: start_q,
                    frame_end:   end_q,
                    sclk_fall:   fall_q,
                    byte_vld:    byte_q,
                    data:        data_q};

endmodule

// ==== source/spi_tx_shift.sv ====
// SPI transmit stage
//   Holds the word returned by the Avalon read
//   Shifts it onto MISO, MSB first, one bit per falling sclk
//   Returns MISO to 0 at frame end or after the last bit

`timescale 1ns/1ps

module spi_tx_shift (
   input  logic                i_avmm_clk,
   input  logic                i_rst_n,
   input  spi_pkg::spi_evt_t   i_evt,
   input  avmm_pkg::avmm_rsp_t i_rsp,
   input  logic                i_tx_arm,
   output logic                o_miso
);
   import avmm_pkg::*;

   localparam logic [5:0] LAST_BIT = 6'(AVMM_DATA_W);

   logic [AVMM_DATA_W-1:0] tx_word;  // Shifts left as bits go out
   logic [5:0]             bit_cnt;
   logic                   armed;
   logic                   miso_q;
   logic                   shift_en;

   assign shift_en = armed & i_evt.sclk_fall & (bit_cnt != LAST_BIT);

   always_ff @(posedge i_avmm_clk) begin
      if (!i_rst_n) begin
         armed   <= 1'b0;
         bit_cnt <= '0;
         miso_q  <= 1'b0;
      end else if (i_evt.frame_end || !i_evt.sel) begin
         armed  <= 1'b0;
         miso_q <= 1'b0;
      end else if (i_tx_arm) begin
         armed   <= 1'b1;
         bit_cnt <= '0;
      end else if (shift_en) begin
         miso_q  <= tx_word[AVMM_DATA_W-1];
         bit_cnt <= bit_cnt + 6'd1;
      end else if (armed && i_evt.sclk_fall) begin
         // Fall after bit 0, word is done
         armed  <= 1'b0;
         miso_q <= 1'b0;
      end
   end

   always_ff @(posedge i_avmm_clk) begin
      if (i_rsp.vld) begin
         tx_word <= i_rsp.rdata;
      end else if (shift_en) begin
         tx_word <= {tx_word[AVMM_DATA_W-2:0], 1'b0};
      end
   end

   assign o_miso = miso_q;

endmodule

// ==== src.f ====
source/spi_pkg.sv
source/avmm_pkg.sv
source/spi_rx_shift.sv
source/spi_frame_decode.sv
source/avmm_master_port.sv
source/spi_tx_shift.sv
source/spi_avmm_bridge.sv
dv/spi_avmm_bridge_chk.sv
dv/spi_avmm_bridge_tb.sv
